// File: hdl/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Pixel and kernel weight width
`define CONV_PIX_W 16

// Bias input width
`define CONV_BIAS_W 16

// Full precision sum of nine 32-bit products plus bias
`define CONV_RES_W 40

// Widest supported image, sets the row buffer length
`define CONV_MAX_W 64

// Result FIFO entries
`define CONV_FIFO_DEPTH 16

// Windows between line_window and the FIFO write port
`define CONV_INFLIGHT 3

`endif

// File: hdl/conv_pkg.sv
`default_nettype none

`include "conv_params.svh"

package conv_pkg;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_KERNEL,
        STREAM,
        DRAIN
    } ctrl_state_t;

    // Encoding as seen on the size_sel input
    typedef enum logic [1:0] {
        SIZE_8  = 2'd0,
        SIZE_16 = 2'd1,
        SIZE_32 = 2'd2,
        SIZE_64 = 2'd3
    } size_sel_t;

    typedef logic signed [`CONV_PIX_W-1:0] pix_t;

    // Index 0 is the top left pixel, row-major
    typedef struct packed {
        pix_t [8:0] pix;
        logic       last;
    } window_t;

    typedef struct packed {
        logic signed [`CONV_RES_W-1:0] sum;
        logic                          last;
    } result_t;

endpackage

`default_nettype wire

// File: hdl/conv_control.sv
`timescale 1ns/1ps
`default_nettype none

module conv_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                load_kernel,
    input  conv_pkg::size_sel_t size_sel,
    input  logic                s_axis_tvalid,
    input  logic                s_axis_tlast,
    input  logic                almost_full,
    input  logic                last_pop,
    output logic                s_axis_tready,
    output logic                pix_accept,
    output logic                weight_load,
    output logic                bias_capture,
    output logic [7:0]          image_width,
    output logic                conv_done
);

    conv_pkg::ctrl_state_t state;
    logic [3:0]            weight_cnt;
    logic [12:0]           pix_cnt;
    logic [12:0]           pix_total;
    logic [7:0]            width_dec;
    logic                  weight_last;
    logic                  pix_last;

    always_comb begin
        case (size_sel)
            conv_pkg::SIZE_8:  width_dec = 8'd8;
            conv_pkg::SIZE_16: width_dec = 8'd16;
            conv_pkg::SIZE_32: width_dec = 8'd32;
            default:           width_dec = 8'd64;
        endcase
    end

    // Pixels per image for the latched width
    assign pix_total = 13'(image_width) * 13'(image_width);

    // Input is open for weights always, for pixels only while the FIFO has room
    assign s_axis_tready = (state == conv_pkg::LOAD_KERNEL) ||
                           ((state == conv_pkg::STREAM) && !almost_full);

    assign weight_load  = s_axis_tvalid && s_axis_tready && (state == conv_pkg::LOAD_KERNEL);
    assign pix_accept   = s_axis_tvalid && s_axis_tready && (state == conv_pkg::STREAM);
    assign weight_last  = (weight_cnt == 4'd8);
    assign bias_capture = weight_load && weight_last;
    assign pix_last     = (pix_cnt == pix_total - 13'd1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= conv_pkg::IDLE;
            weight_cnt  <= '0;
            pix_cnt     <= '0;
            image_width <= 8'd8;
            conv_done   <= 1'b0;
        end else begin
            conv_done <= 1'b0;
            case (state)
                conv_pkg::IDLE: begin
                    weight_cnt <= '0;
                    pix_cnt    <= '0;
                    if (load_kernel) begin
                        state <= conv_pkg::LOAD_KERNEL;
                    end else if (s_axis_tvalid) begin
                        // Stored kernel is reused
                        image_width <= width_dec;
                        state       <= conv_pkg::STREAM;
                    end
                end
                conv_pkg::LOAD_KERNEL: begin
                    if (weight_load) begin
                        weight_cnt <= weight_cnt + 4'd1;
                        if (weight_last) begin
                            image_width <= width_dec;
                            state       <= conv_pkg::STREAM;
                        end
                    end
                end
                conv_pkg::STREAM: begin
                    if (pix_accept) begin
                        pix_cnt <= pix_cnt + 13'd1;
                        if (pix_last) begin
                            state <= conv_pkg::DRAIN;
                        end
                    end
                end
                conv_pkg::DRAIN: begin
                    // Wait for the final result to leave the FIFO
                    if (last_pop) begin
                        conv_done <= 1'b1;
                        state     <= conv_pkg::IDLE;
                    end
                end
                default: state <= conv_pkg::IDLE;
            endcase
        end
    end

    // Source framing must agree with the selected image size
    assert property (@(posedge clk) disable iff (reset)
        (pix_accept && pix_last) |-> s_axis_tlast)
        else $error("conv_control: image end without s_axis_tlast");

    assert property (@(posedge clk) disable iff (reset)
        conv_done |=> !conv_done)
        else $error("conv_control: conv_done longer than one cycle");

endmodule

`default_nettype wire

// File: hdl/line_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module line_window (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`CONV_PIX_W-1:0] pix,
    input  logic                   pix_accept,
    input  logic [7:0]             image_width,
    output conv_pkg::window_t      win,
    output logic                   win_valid
);

    localparam int COL_W = $clog2(`CONV_MAX_W);

    // Previous row and the one before it
    logic [`CONV_PIX_W-1:0] row1_buf [`CONV_MAX_W];
    logic [`CONV_PIX_W-1:0] row2_buf [`CONV_MAX_W];

    conv_pkg::pix_t         top_sr [3];
    conv_pkg::pix_t         mid_sr [3];
    conv_pkg::pix_t         bot_sr [3];
    logic [COL_W-1:0]       col;
    logic [COL_W-1:0]       row;
    logic [`CONV_PIX_W-1:0] above1;
    logic [`CONV_PIX_W-1:0] above2;
    logic                   col_end;
    logic                   row_end;
    logic                   full_pos;
    logic                   last_q;

    assign above1   = row1_buf[col];
    assign above2   = row2_buf[col];
    assign col_end  = (8'(col) == image_width - 8'd1);
    assign row_end  = (8'(row) == image_width - 8'd1);
    // No padding, so the first two rows and columns give no window
    assign full_pos = (row >= COL_W'(2)) && (col >= COL_W'(2));

    always_ff @(posedge clk) begin
        if (pix_accept) begin
            row2_buf[col] <= above1;
            row1_buf[col] <= pix;
        end
    end

    // Oldest column sits at index 0
    always_ff @(posedge clk) begin
        if (pix_accept) begin
            top_sr[0] <= top_sr[1];
            top_sr[1] <= top_sr[2];
            top_sr[2] <= above2;
            mid_sr[0] <= mid_sr[1];
            mid_sr[1] <= mid_sr[2];
            mid_sr[2] <= above1;
            bot_sr[0] <= bot_sr[1];
            bot_sr[1] <= bot_sr[2];
            bot_sr[2] <= pix;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            col       <= '0;
            row       <= '0;
            win_valid <= 1'b0;
            last_q    <= 1'b0;
        end else begin
            win_valid <= pix_accept && full_pos;
            if (pix_accept) begin
                last_q <= col_end && row_end;
                if (col_end) begin
                    col <= '0;
                    // Wrap at image end for the next frame
                    row <= row_end ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            win.pix[i]     = top_sr[i];
            win.pix[i + 3] = mid_sr[i];
            win.pix[i + 6] = bot_sr[i];
        end
        win.last = last_q;
    end

endmodule

`default_nettype wire

// File: hdl/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module conv_mac (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CONV_PIX_W-1:0]  pix,
    input  logic                    weight_load,
    input  logic                    bias_capture,
    input  logic [`CONV_BIAS_W-1:0] bias,
    input  conv_pkg::window_t       win,
    input  logic                    win_valid,
    output conv_pkg::result_t       res,
    output logic                    res_valid
);

    conv_pkg::pix_t                  weight [9];
    logic signed [`CONV_BIAS_W-1:0]  bias_q;
    logic signed [2*`CONV_PIX_W-1:0] prod [9];
    logic                            s1_valid;
    logic                            s1_last;
    logic signed [`CONV_RES_W-1:0]   sum_pair [4];
    logic signed [`CONV_RES_W-1:0]   sum_quad [2];
    logic signed [`CONV_RES_W-1:0]   sum_tail;
    logic signed [`CONV_RES_W-1:0]   sum_all;

    // Weights shift toward index 0, so the first loaded ends up top left
    always_ff @(posedge clk) begin
        if (weight_load) begin
            for (int i = 0; i < 8; i++) begin
                weight[i] <= weight[i + 1];
            end
            weight[8] <= pix;
        end
        if (bias_capture) begin
            bias_q <= bias;
        end
    end

    // Stage 1 multiplies
    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int i = 0; i < 9; i++) begin
                prod[i] <= $signed(win.pix[i]) * weight[i];
            end
            s1_last <= win.last;
        end
    end

    // Stage 2 adder tree, bias rides with the ninth product
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            sum_pair[i] = prod[2 * i] + prod[2 * i + 1];
        end
        sum_tail    = prod[8] + bias_q;
        sum_quad[0] = sum_pair[0] + sum_pair[1];
        sum_quad[1] = sum_pair[2] + sum_pair[3];
        sum_all     = sum_quad[0] + sum_quad[1] + sum_tail;
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            res.sum  <= sum_all;
            res.last <= s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= win_valid;
            res_valid <= s1_valid;
        end
    end

    // Kernel must stay fixed while a window is still in the pipeline
    assert property (@(posedge clk) disable iff (reset)
        weight_load |-> !win_valid && !s1_valid && !res_valid)
        else $error("conv_mac: kernel load with windows in flight");

endmodule

`default_nettype wire

// File: hdl/result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module result_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  conv_pkg::result_t      res,
    input  logic                   res_valid,
    input  logic                   m_axis_tready,
    output logic [`CONV_RES_W-1:0] m_axis_tdata,
    output logic                   m_axis_tvalid,
    output logic                   m_axis_tlast,
    output logic                   almost_full,
    output logic                   last_pop
);

    localparam int PTR_W = $clog2(`CONV_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`CONV_FIFO_DEPTH + 1);

    conv_pkg::result_t mem [`CONV_FIFO_DEPTH];
    conv_pkg::result_t head;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    assign head          = mem[rd_ptr];
    assign m_axis_tvalid = (count != '0);
    assign m_axis_tdata  = head.sum;
    assign m_axis_tlast  = m_axis_tvalid && head.last;
    assign push          = res_valid;
    assign pop           = m_axis_tvalid && m_axis_tready;
    assign last_pop      = pop && head.last;
    // Leaves room for every window already past the input
    assign almost_full   = (`CONV_FIFO_DEPTH - count) <= `CONV_INFLIGHT;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= res;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`CONV_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`CONV_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        push |-> (count != CNT_W'(`CONV_FIFO_DEPTH)))
        else $error("result_fifo: write while full");

endmodule

`default_nettype wire

// File: hdl/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module conv_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_kernel,
    input  logic [1:0]              size_sel,
    input  logic [`CONV_BIAS_W-1:0] bias,
    input  logic [`CONV_PIX_W-1:0]  s_axis_tdata,
    input  logic                    s_axis_tvalid,
    output logic                    s_axis_tready,
    input  logic                    s_axis_tlast,
    output logic [`CONV_RES_W-1:0]  m_axis_tdata,
    output logic                    m_axis_tvalid,
    input  logic                    m_axis_tready,
    output logic                    m_axis_tlast,
    output logic                    conv_done
);

    logic              pix_accept;
    logic              weight_load;
    logic              bias_capture;
    logic [7:0]        image_width;
    logic              almost_full;
    logic              last_pop;
    conv_pkg::window_t win;
    logic              win_valid;
    conv_pkg::result_t res;
    logic              res_valid;

    conv_control u_control (
        .clk           (clk),
        .reset         (reset),
        .load_kernel   (load_kernel),
        .size_sel      (conv_pkg::size_sel_t'(size_sel)),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .almost_full   (almost_full),
        .last_pop      (last_pop),
        .s_axis_tready (s_axis_tready),
        .pix_accept    (pix_accept),
        .weight_load   (weight_load),
        .bias_capture  (bias_capture),
        .image_width   (image_width),
        .conv_done     (conv_done)
    );

    // Producer side of the datapath
    line_window u_window (
        .clk         (clk),
        .reset       (reset),
        .pix         (s_axis_tdata),
        .pix_accept  (pix_accept),
        .image_width (image_width),
        .win         (win),
        .win_valid   (win_valid)
    );

    conv_mac u_mac (
        .clk          (clk),
        .reset        (reset),
        .pix          (s_axis_tdata),
        .weight_load  (weight_load),
        .bias_capture (bias_capture),
        .bias         (bias),
        .win          (win),
        .win_valid    (win_valid),
        .res          (res),
        .res_valid    (res_valid)
    );

    result_fifo u_fifo (
        .clk           (clk),
        .reset         (reset),
        .res           (res),
        .res_valid     (res_valid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .almost_full   (almost_full),
        .last_pop      (last_pop)
    );

endmodule

`default_nettype wire

// File: tb/tb_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module tb_conv_top;

    localparam int res_w = `CONV_RES_W;
    // Pixels of all images in the run, sets the hang limit
    localparam int total_pixels = 64 + 256 + 1024 + 64 + 4096 + 64;
    localparam int cycle_limit = 4 * total_pixels + 2000;

    logic                    clk;
    logic                    reset;
    logic                    load_kernel;
    logic [1:0]              size_sel;
    logic [`CONV_BIAS_W-1:0] bias;
    logic [`CONV_PIX_W-1:0]  s_axis_tdata;
    logic                    s_axis_tvalid;
    logic                    s_axis_tready;
    logic                    s_axis_tlast;
    logic [`CONV_RES_W-1:0]  m_axis_tdata;
    logic                    m_axis_tvalid;
    logic                    m_axis_tready;
    logic                    m_axis_tlast;
    logic                    conv_done;

    logic [31:0] gen_lfsr = 32'h2b14b96d;
    logic [31:0] sink_lfsr = 32'h2b14b96d;
    int          img [`CONV_MAX_W * `CONV_MAX_W];
    int          kern [9];
    int          bias_val;
    longint      exp_q [$];
    int          exp_total;
    int          rx_count;
    int          done_count;
    int          cycle_count;
    bit          ready_random;
    bit          valid_gaps;
    string       test_name;

    conv_top uut (
        .clk           (clk),
        .reset         (reset),
        .load_kernel   (load_kernel),
        .size_sel      (size_sel),
        .bias          (bias),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tlast  (s_axis_tlast),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .conv_done     (conv_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            gen_lfsr = lfsr_next(gen_lfsr);
            v = {v[30:0], gen_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic signed [15:0] rand_pix();
        logic [31:0] v;
        v = rand_bits(16);
        return v[15:0];
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input logic [res_w-1:0] expected,
                               input logic [res_w-1:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("** Error: %s: %s expected %h, actual %h",
                               test_name, what, expected, actual));
        end
    endtask

    // Valid windows only, raster order, full precision
    task automatic build_expected(input int n);
        longint acc;
        exp_q.delete();
        for (int r = 0; r < n - 2; r++) begin
            for (int c = 0; c < n - 2; c++) begin
                acc = longint'(bias_val);
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        acc += longint'(img[(r + i) * n + c + j]) * longint'(kern[i * 3 + j]);
                    end
                end
                exp_q.push_back(acc);
            end
        end
        exp_total = exp_q.size();
        rx_count  = 0;
    endtask

    task automatic fill_image(input int n);
        for (int k = 0; k < n * n; k++) begin
            img[k] = int'(rand_pix());
        end
    endtask

    task automatic random_kernel();
        for (int k = 0; k < 9; k++) begin
            kern[k] = int'(rand_pix());
        end
        bias_val = int'(rand_pix());
    endtask

    // Called on a falling edge, returns one falling edge after the beat transfers
    task automatic send_beat(input logic [15:0] data, input logic last);
        while (valid_gaps && (rand_bits(1) != 0)) begin
            s_axis_tvalid = 1'b0;
            @(negedge clk);
        end
        s_axis_tdata  = data;
        s_axis_tvalid = 1'b1;
        s_axis_tlast  = last;
        // tready only changes on the rising edge
        while (!s_axis_tready) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic run_image(input int n, input bit load);
        case (n)
            8:       size_sel = 2'd0;
            16:      size_sel = 2'd1;
            32:      size_sel = 2'd2;
            default: size_sel = 2'd3;
        endcase
        build_expected(n);
        done_count = 0;
        check_value("s_axis_tready in IDLE", '0, res_w'(s_axis_tready));
        if (load) begin
            load_kernel = 1'b1;
            bias        = 16'(bias_val);
            for (int k = 0; k < 9; k++) begin
                send_beat(16'(kern[k]), 1'b0);
            end
            load_kernel = 1'b0;
        end
        for (int k = 0; k < n * n; k++) begin
            send_beat(16'(img[k]), k == n * n - 1);
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        while (done_count == 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_value("conv_done pulses", res_w'(1), res_w'(done_count));
        check_value("result count", res_w'(exp_total), res_w'(rx_count));
    endtask

    task automatic test_identity();
        test_name = "identity_8x8";
        for (int k = 0; k < 9; k++) begin
            kern[k] = (k == 4) ? 1 : 0;
        end
        bias_val = 0;
        fill_image(8);
        run_image(8, 1'b1);
    endtask

    task automatic test_random_16();
        test_name = "random_16x16";
        random_kernel();
        fill_image(16);
        run_image(16, 1'b1);
    endtask

    task automatic test_backpressure_32();
        test_name    = "backpressure_32x32";
        ready_random = 1'b1;
        valid_gaps   = 1'b1;
        random_kernel();
        fill_image(32);
        run_image(32, 1'b1);
        ready_random = 1'b0;
        valid_gaps   = 1'b0;
    endtask

    task automatic test_framing();
        test_name = "framing_8x8";
        // Nothing offered, so the input must stay closed
        repeat (5) begin
            @(negedge clk);
            check_value("s_axis_tready idle", '0, res_w'(s_axis_tready));
        end
        ready_random = 1'b1;
        fill_image(8);
        run_image(8, 1'b0);
        ready_random = 1'b0;
    endtask

    task automatic test_reload();
        test_name = "reuse_64x64";
        fill_image(64);
        run_image(64, 1'b0);
        test_name = "reload_8x8";
        random_kernel();
        fill_image(8);
        run_image(8, 1'b1);
    endtask

    // Output sink and checker
    initial begin
        forever begin
            @(negedge clk);
            if (ready_random) begin
                sink_lfsr     = lfsr_next(sink_lfsr);
                m_axis_tready = sink_lfsr[0];
            end else begin
                m_axis_tready = 1'b1;
            end
            if (conv_done) begin
                done_count++;
                check_value("results before conv_done", res_w'(exp_total), res_w'(rx_count));
            end
            // Beat transfers on the coming rising edge
            if (m_axis_tvalid && m_axis_tready) begin
                if (exp_q.size() == 0) begin
                    fail_run($sformatf("%s: result beat arrived with none expected", test_name));
                end else begin
                    check_value("m_axis_tdata", res_w'(exp_q.pop_front()), m_axis_tdata);
                    check_value("m_axis_tlast", res_w'(rx_count == exp_total - 1),
                                res_w'(m_axis_tlast));
                    rx_count++;
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                fail_run($sformatf("Timeout after %0d cycles in %s, the DUT appears hung",
                                   cycle_count, test_name));
            end
        end
    end

    initial begin
        reset         = 1'b1;
        load_kernel   = 1'b0;
        size_sel      = 2'd0;
        bias          = '0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = 1'b0;
        ready_random  = 1'b0;
        valid_gaps    = 1'b0;
        done_count    = 0;
        rx_count      = 0;
        exp_total     = 0;
        test_name     = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_identity();
        test_random_16();
        test_backpressure_32();
        test_framing();
        test_reload();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/conv_pkg.sv
hdl/conv_control.sv
hdl/line_window.sv
hdl/conv_mac.sv
hdl/result_fifo.sv
hdl/conv_top.sv
tb/tb_conv_top.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_conv_top
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Pass or fail comes from the log, not from the simulator status
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
